/* verilog/hdc_settings.svh */
`ifndef HDC_SETTINGS_SVH
`define HDC_SETTINGS_SVH

// width of one core's slice of the hypervector
`define HV_WORD_BITS 32

// cores, and output words per hypervector
`define NUM_CORES 8

// symbol width, item memory depth is 2**SYMBOL_BITS
`define SYMBOL_BITS 7

// ingress FIFO depth, also the sender's starting credits
`define IN_DEPTH 4

// credits granted by the sink after reset
`define OUT_CREDITS 2

// item rule: base + core * core_stride + symbol * item_stride
`define ITEM_BASE 33215360
`define ITEM_STRIDE 18360
`define CORE_STRIDE 1000003

`endif

/* verilog/hdc_pkg.sv */
`default_nettype none

`include "hdc_settings.svh"

package hdc_pkg;

    // one core's slice of a hypervector
    typedef logic [`HV_WORD_BITS-1:0] hv_word_t;

    // item memory index
    typedef logic [`SYMBOL_BITS-1:0] symbol_t;

    // rotation amount, wraps at the word width
    typedef logic [$clog2(`HV_WORD_BITS)-1:0] position_t;

    // ingress FIFO entry
    typedef struct packed {
        symbol_t symbol;
        logic    last;
    } sym_entry_t;

endpackage

`default_nettype wire

/* verilog/credit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  entry_t                       push_data,
    input  logic                         pop,
    output entry_t                       pop_data,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   free_count
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);
    localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(DEPTH - 1);
    localparam logic [CNT_BITS-1:0] CNT_FULL = CNT_BITS'(DEPTH);

    entry_t mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_push;
    logic                do_pop;

    // full and empty guards, a well behaved sender never hits them
    assign do_push = push && (count != CNT_FULL);
    assign do_pop  = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
        end
    end

    // show-ahead head, valid whenever not empty
    assign pop_data   = mem[rd_ptr];
    assign empty      = (count == '0);
    assign free_count = CNT_FULL - count;

endmodule

`default_nettype wire

/* verilog/item_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_settings.svh"

module item_memory import hdc_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  logic     clk,
    input  symbol_t  addr,
    output hv_word_t data
);

    localparam int ITEM_COUNT = 1 << `SYMBOL_BITS;

    hv_word_t rom [ITEM_COUNT];

    // fixed contents, every term wraps modulo 2**32
    initial begin
        for (int i = 0; i < ITEM_COUNT; i++) begin
            rom[i] = hv_word_t'(`ITEM_BASE)
                   + hv_word_t'(CORE_ID) * hv_word_t'(`CORE_STRIDE)
                   + hv_word_t'(i) * hv_word_t'(`ITEM_STRIDE);
        end
    end

    // registered read, the t+1 stage of the core
    always_ff @(posedge clk) begin
        data <= rom[addr];
    end

endmodule

`default_nettype wire

/* verilog/bind_core.sv */
`timescale 1ns/1ps
`default_nettype none

module bind_core import hdc_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     init,
    input  logic     exec,
    input  symbol_t  symbol,
    input  logic     load,
    input  logic     shift,
    input  hv_word_t chain_in,
    output hv_word_t chain_out
);

    logic      exec_d1;
    logic      exec_d2;
    logic      exec_d3;
    logic      init_d1;
    logic      init_d2;
    symbol_t   sym_d1;
    hv_word_t  item_word;
    hv_word_t  operand;
    hv_word_t  rotated;
    hv_word_t  acc;
    position_t position;
    hv_word_t  chain_reg;

    // control pipeline, exec three deep and init two deep
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec_d1 <= 1'b0;
            exec_d2 <= 1'b0;
            exec_d3 <= 1'b0;
            init_d1 <= 1'b0;
            init_d2 <= 1'b0;
        end else begin
            exec_d1 <= exec;
            exec_d2 <= exec_d1;
            exec_d3 <= exec_d2;
            init_d1 <= init;
            init_d2 <= init_d1;
        end
    end

    always_ff @(posedge clk) begin
        sym_d1 <= symbol;
    end

    item_memory #(
        .CORE_ID (CORE_ID)
    ) u_item_memory (
        .clk  (clk),
        .addr (sym_d1),
        .data (item_word)
    );

    // operand register breaks the rom to rotator path
    always_ff @(posedge clk) begin
        if (exec_d2) begin
            operand <= item_word;
        end
    end

    // rotate right by position
    assign rotated = hv_word_t'({operand, operand} >> position);

    // init wins, clears just before the first accumulate
    always_ff @(posedge clk) begin
        if (init_d2) begin
            acc <= '0;
        end else if (exec_d3) begin
            acc <= acc ^ rotated;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            position <= '0;
        end else if (init_d2) begin
            position <= '0;
        end else if (exec_d3) begin
            position <= position + 1'b1;
        end
    end

    // unload chain stage
    always_ff @(posedge clk) begin
        if (load) begin
            chain_reg <= acc;
        end else if (shift) begin
            chain_reg <= chain_in;
        end
    end

    assign chain_out = chain_reg;

endmodule

`default_nettype wire

/* verilog/encode_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_settings.svh"

module encode_sequencer import hdc_pkg::*; #(
    parameter int OUT_DEPTH = 16
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_empty,
    input  sym_entry_t                       in_entry,
    output logic                             in_pop,
    output logic                             in_credit,
    output logic                             init,
    output logic                             exec,
    output symbol_t                          symbol,
    output logic                             load,
    output logic                             shift,
    input  logic [$clog2(OUT_DEPTH+1)-1:0]   out_free,
    input  logic                             out_empty,
    output logic                             out_push,
    output logic                             out_pop,
    output logic                             out_valid,
    input  logic                             out_credit
);

    localparam int FREE_BITS  = $clog2(OUT_DEPTH + 1);
    localparam int CRED_BITS  = $clog2(`OUT_CREDITS + 1);
    localparam int SHIFT_BITS = ($clog2(`NUM_CORES) > 0) ? $clog2(`NUM_CORES) : 1;

    localparam logic [1:0]            DRAIN_LAST = 2'd3;
    localparam logic [SHIFT_BITS-1:0] SHIFT_LAST = SHIFT_BITS'(`NUM_CORES - 1);
    localparam logic [FREE_BITS-1:0]  HV_WORDS   = FREE_BITS'(`NUM_CORES);
    localparam logic [CRED_BITS-1:0]  CRED_INIT  = CRED_BITS'(`OUT_CREDITS);

    logic                  first_sym;
    logic                  load_pending;
    logic [1:0]            drain_cnt;
    logic                  unloading;
    logic [SHIFT_BITS-1:0] shift_cnt;
    logic [CRED_BITS-1:0]  out_credits;

    // pops stop from the last symbol until its load goes out
    assign in_pop = !in_empty && !load_pending;
    assign exec   = in_pop;
    assign init   = in_pop && first_sym;
    assign symbol = in_entry.symbol;

    // wait for the final accumulate, a free chain and room for a whole hypervector
    assign load = load_pending && (drain_cnt == DRAIN_LAST) && !unloading
                  && (out_free >= HV_WORDS);

    assign shift    = unloading;
    assign out_push = shift;

    // egress pops only against a held credit
    assign out_pop   = !out_empty && (out_credits != '0);
    assign out_valid = out_pop;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            first_sym <= 1'b1;
        end else if (in_pop) begin
            first_sym <= in_entry.last;
        end
    end

    // drain counter, the final accumulate lands at the end of t+3
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_pending <= 1'b0;
            drain_cnt    <= '0;
        end else if (in_pop && in_entry.last) begin
            load_pending <= 1'b1;
            drain_cnt    <= '0;
        end else if (load) begin
            load_pending <= 1'b0;
        end else if (load_pending && (drain_cnt != DRAIN_LAST)) begin
            drain_cnt <= drain_cnt + 1'b1;
        end
    end

    // NUM_CORES shifts per hypervector
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            unloading <= 1'b0;
            shift_cnt <= '0;
        end else if (load) begin
            unloading <= 1'b1;
            shift_cnt <= '0;
        end else if (unloading) begin
            if (shift_cnt == SHIFT_LAST) begin
                unloading <= 1'b0;
            end else begin
                shift_cnt <= shift_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_credits <= CRED_INIT;
        end else begin
            out_credits <= out_credits + CRED_BITS'(out_credit) - CRED_BITS'(out_pop);
        end
    end

    // one credit back per ingress pop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= in_pop;
        end
    end

endmodule

`default_nettype wire

/* verilog/hdc_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_settings.svh"

module hdc_encoder import hdc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  symbol_t  in_symbol,
    input  logic     in_last,
    output logic     in_credit,
    output logic     out_valid,
    output hv_word_t out_word,
    input  logic     out_credit
);

    // egress holds two hypervectors
    localparam int OUT_DEPTH = 2 * `NUM_CORES;

    sym_entry_t                          in_entry_w;
    sym_entry_t                          in_head;
    logic                                in_empty;
    logic                                in_pop;
    logic [$clog2(`IN_DEPTH+1)-1:0]      in_free;
    logic                                init;
    logic                                exec;
    symbol_t                             symbol;
    logic                                load;
    logic                                shift;
    logic                                out_push;
    logic                                out_pop;
    logic                                out_empty;
    logic [$clog2(OUT_DEPTH+1)-1:0]      out_free;
    hv_word_t                            chain [`NUM_CORES+1];

    assign in_entry_w.symbol = in_symbol;
    assign in_entry_w.last   = in_last;

    credit_fifo #(
        .entry_t (sym_entry_t),
        .DEPTH   (`IN_DEPTH)
    ) u_in_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (in_valid),
        .push_data  (in_entry_w),
        .pop        (in_pop),
        .pop_data   (in_head),
        .empty      (in_empty),
        .free_count (in_free)
    );

    encode_sequencer #(
        .OUT_DEPTH (OUT_DEPTH)
    ) u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_empty   (in_empty),
        .in_entry   (in_head),
        .in_pop     (in_pop),
        .in_credit  (in_credit),
        .init       (init),
        .exec       (exec),
        .symbol     (symbol),
        .load       (load),
        .shift      (shift),
        .out_free   (out_free),
        .out_empty  (out_empty),
        .out_push   (out_push),
        .out_pop    (out_pop),
        .out_valid  (out_valid),
        .out_credit (out_credit)
    );

    // top of the chain shifts in zeros
    assign chain[`NUM_CORES] = '0;

    for (genvar k = 0; k < `NUM_CORES; k++) begin : g_core
        bind_core #(
            .CORE_ID (k)
        ) u_core (
            .clk       (clk),
            .rst_n     (rst_n),
            .init      (init),
            .exec      (exec),
            .symbol    (symbol),
            .load      (load),
            .shift     (shift),
            .chain_in  (chain[k+1]),
            .chain_out (chain[k])
        );
    end

    credit_fifo #(
        .entry_t (hv_word_t),
        .DEPTH   (OUT_DEPTH)
    ) u_out_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (out_push),
        .push_data  (chain[0]),
        .pop        (out_pop),
        .pop_data   (out_word),
        .empty      (out_empty),
        .free_count (out_free)
    );

endmodule

`default_nettype wire

/* verification/hdc_encoder_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_settings.svh"

module hdc_encoder_asserts (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             in_valid,
    input logic [$clog2(`IN_DEPTH+1)-1:0]   in_free,
    input logic                             in_credit,
    input logic                             out_valid,
    input logic                             out_credit
);

    int out_credits;

    // shadow of the output credit count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_credits <= `OUT_CREDITS;
        end else begin
            out_credits <= out_credits + int'(out_credit) - int'(out_valid);
        end
    end

    out_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_credits > 0)
        else $error("out_valid asserted without an output credit");

    no_ingress_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> in_free != '0)
        else $error("ingress FIFO pushed while full");

    // first cycle out of reset is quiet
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |=> !in_credit && !out_valid)
        else $error("in_credit or out_valid high in the cycle after reset");

endmodule

bind hdc_encoder hdc_encoder_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_free    (in_free),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_credit (out_credit)
);

`default_nettype wire

/* verification/hdc_encoder_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_settings.svh"

module hdc_encoder_tb import hdc_pkg::*; ();

    localparam int DRIVE_DELAY = 1;
    localparam int EXP_SIZE    = 4096;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    symbol_t  in_symbol;
    logic     in_last;
    logic     in_credit;
    logic     out_valid;
    hv_word_t out_word;
    logic     out_credit;

    // source and sink state
    symbol_t  src_sym_q [$];
    logic     src_last_q [$];
    int       src_credits;
    int       owed;
    logic     seen_input;
    logic     src_gaps;
    logic     sink_stalls;
    logic     sink_hold;

    // expected words in output order
    hv_word_t exp_mem [EXP_SIZE];
    int       exp_wr;
    int       exp_rd;

    hdc_encoder DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_symbol  (in_symbol),
        .in_last    (in_last),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .out_credit (out_credit)
    );

    always #5 clk = ~clk;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src_credits   <= `IN_DEPTH;
            owed          <= 0;
            exp_rd        <= 0;
            seen_input    <= 1'b0;
        end else begin
            src_credits   <= src_credits - int'(in_valid) + int'(in_credit);
            owed          <= owed + int'(out_valid) - int'(out_credit);
            exp_rd        <= exp_rd + int'(out_valid);
            seen_input    <= seen_input || in_valid;
        end
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    word_matches_model: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (exp_rd < exp_wr) && (out_word == exp_mem[exp_rd]))
    else begin
        $display("** Error at %0t ns: out_word %h, expected %h for word %0d",
                 $time, $sampled(out_word), exp_mem[$sampled(exp_rd)], $sampled(exp_rd));
        abort_run();
    end

    credit_not_overreturned: assert property (@(posedge clk) disable iff (!rst_n)
        src_credits <= `IN_DEPTH)
    else begin
        $display("at %0t ns the DUT returned more input credits than beats sent", $time);
        abort_run();
    end

    quiet_until_input: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_input |-> !out_valid && !in_credit)
    else begin
        $display("at %0t ns out_valid or in_credit rose before any input", $time);
        abort_run();
    end

    // item rule evaluated in 64 bits, then taken modulo 2**32
    function automatic hv_word_t item_entry(input int core, input int sym);
        longint v;
        v = longint'(`ITEM_BASE) + longint'(core) * longint'(`CORE_STRIDE)
            + longint'(sym) * longint'(`ITEM_STRIDE);
        return hv_word_t'(v);
    endfunction

    function automatic hv_word_t rotate_right(input hv_word_t w, input int amount);
        int r;
        r = amount % `HV_WORD_BITS;
        if (r == 0) begin
            return w;
        end
        return (w >> r) | (w << (`HV_WORD_BITS - r));
    endfunction

    task automatic queue_sequence(input symbol_t syms [$]);
        hv_word_t acc;
        for (int core = 0; core < `NUM_CORES; core++) begin
            acc = '0;
            for (int i = 0; i < syms.size(); i++) begin
                acc = acc ^ rotate_right(item_entry(core, int'(syms[i])), i);
            end
            exp_mem[exp_wr] = acc;
            exp_wr++;
        end
        foreach (syms[i]) begin
            src_sym_q.push_back(syms[i]);
            src_last_q.push_back(i == syms.size() - 1);
        end
    endtask

    task automatic queue_random_sequence(input int len);
        symbol_t syms [$];
        for (int i = 0; i < len; i++) begin
            syms.push_back(symbol_t'($urandom_range((1 << `SYMBOL_BITS) - 1)));
        end
        queue_sequence(syms);
    endtask

    // one beat per cycle at most, only against a held credit
    task automatic drive_source();
        forever begin
            @(posedge clk);
            #(DRIVE_DELAY);
            in_valid = 1'b0;
            if (src_credits > 0 && src_sym_q.size() > 0
                && !(src_gaps && $urandom_range(3) == 0)) begin
                in_valid  = 1'b1;
                in_symbol = src_sym_q.pop_front();
                in_last   = src_last_q.pop_front();
            end
        end
    endtask

    // returns one credit per word received, with optional long holds
    task automatic drive_sink();
        int hold_left = 0;
        forever begin
            @(posedge clk);
            #(DRIVE_DELAY);
            out_credit = 1'b0;
            if (sink_stalls && hold_left == 0 && $urandom_range(15) == 0) begin
                hold_left = 20 + int'($urandom_range(60));
            end
            if (hold_left > 0) begin
                hold_left--;
            end else if (owed > 0 && !sink_hold) begin
                out_credit = 1'b1;
            end
        end
    endtask

    task automatic wait_for_drain(input int max_cycles);
        int cycles = 0;
        while (src_sym_q.size() != 0 || exp_rd != exp_wr) begin
            @(posedge clk);
            cycles++;
            if (cycles > max_cycles) begin
                $display("timeout: %0d words still missing after %0d cycles",
                         exp_wr - exp_rd, max_cycles);
                abort_run();
            end
        end
    endtask

    // back-pressure must reach the input port
    task automatic wait_for_ingress_stall(input int quiet_cycles, input int max_cycles);
        int cycles = 0;
        int quiet  = 0;
        while (quiet < quiet_cycles) begin
            @(posedge clk);
            cycles++;
            if (in_credit) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            if (cycles > max_cycles) begin
                $display("timeout: in_credit kept returning while the sink held its credits");
                abort_run();
            end
        end
    endtask

    task automatic wait_for_credits(input int max_cycles);
        int cycles = 0;
        while (src_credits != `IN_DEPTH) begin
            @(posedge clk);
            cycles++;
            if (cycles > max_cycles) begin
                $display("timeout: input credits never all came back");
                abort_run();
            end
        end
    endtask

    initial begin
        symbol_t one_sym [$];
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_symbol   = '0;
        in_last     = 1'b0;
        out_credit  = 1'b0;
        src_gaps    = 1'b0;
        sink_stalls = 1'b0;
        sink_hold   = 1'b0;
        exp_wr      = 0;
        void'($urandom(10));
        fork
            drive_source();
            drive_sink();
        join_none
        repeat (3) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;

        // idle after reset
        repeat (20) @(posedge clk);

        // single symbol, position 0, so plain item entries
        one_sym.push_back(symbol_t'(5));
        queue_sequence(one_sym);
        wait_for_drain(200);

        // long ones wrap the rotation past 32
        src_gaps = 1'b1;
        queue_random_sequence(70);
        queue_random_sequence(33);
        for (int n = 0; n < 40; n++) begin
            queue_random_sequence(1 + int'($urandom_range(69)));
        end
        wait_for_drain(40000);

        // back to back, no gaps
        src_gaps = 1'b0;
        for (int n = 0; n < 30; n++) begin
            queue_random_sequence(1 + int'($urandom_range(9)));
        end
        wait_for_drain(10000);

        // sink holds credits, egress fills and ingress backs up
        sink_stalls = 1'b1;
        sink_hold   = 1'b1;
        for (int n = 0; n < 12; n++) begin
            queue_random_sequence(1 + int'($urandom_range(19)));
        end
        wait_for_ingress_stall(50, 1000);
        sink_hold = 1'b0;
        for (int n = 0; n < 20; n++) begin
            queue_random_sequence(1 + int'($urandom_range(19)));
        end
        wait_for_drain(60000);
        sink_stalls = 1'b0;
        wait_for_credits(100);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hdc_encoder.f */
+incdir+verilog
verilog/hdc_pkg.sv
verilog/credit_fifo.sv
verilog/item_memory.sv
verilog/bind_core.sv
verilog/encode_sequencer.sv
verilog/hdc_encoder.sv
verification/hdc_encoder_asserts.sv
verification/hdc_encoder_tb.sv

/* Makefile */
# Verilator simulation of the hdc_encoder testbench

VERILATOR ?= verilator
TOP       ?= hdc_encoder_tb
FILELIST  ?= hdc_encoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# a simulator exit with an error status also counts as a failed run
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Simulation FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
